//--- hw/fadd_defs.svh
// binary32 format widths and limits, included by the fadd package and stages
`ifndef FADD_DEFS_SVH
`define FADD_DEFS_SVH

// field widths of the binary32 format
`define FP_EXP_W 8
`define FP_FRAC_W 23

// all-ones exponent, infinity or NaN
`define FP_EXP_MAX 255

// guard, round and sticky below the significand
`define FP_GRS_W 3

// canonical quiet NaN
`define FP_QNAN 32'h7fc00000

// shifts at or beyond this keep only sticky
`define FP_ALIGN_MAX 27

`endif

//--- hw/fadd_pkg.sv
// shared types of the pipelined fp adder, imported by every stage and the top
`include "fadd_defs.svh"

package fadd_pkg;

  typedef struct packed {
    logic                  sign;
    logic [`FP_EXP_W-1:0]  exp;
    logic [`FP_FRAC_W-1:0] frac;
  } fp32_t;

  typedef enum logic {
    FADD_ADD = 1'b0,
    FADD_SUB = 1'b1
  } fadd_op_e;

  typedef enum logic [1:0] {
    RND_TRUNC = 2'd0,
    RND_EVEN  = 2'd1,
    RND_PLUS  = 2'd2,
    RND_MINUS = 2'd3
  } round_mode_e;

  // special result that overrides the datapath
  typedef enum logic [1:0] {
    SPEC_NONE = 2'd0,
    SPEC_NAN  = 2'd1,
    SPEC_INF  = 2'd2
  } special_e;

  typedef struct packed {
    logic invalid;
    logic overflow;
    logic underflow;
    logic inexact;
  } fadd_flags_t;

  typedef struct packed {
    logic                              valid;
    round_mode_e                       rmode;
    logic                              sign;
    logic                              eff_sub;
    logic [`FP_EXP_W-1:0]              exp;
    logic [`FP_FRAC_W:0]               big_sig;
    logic [`FP_FRAC_W+`FP_GRS_W:0]     small_sig;
    special_e                          spec;
    logic                              spec_sign;
    logic                              invalid;
  } align_t;

  typedef struct packed {
    logic                              valid;
    round_mode_e                       rmode;
    logic                              sign;
    logic [`FP_EXP_W-1:0]              exp;
    // carry, significand and guard bits
    logic [`FP_FRAC_W+`FP_GRS_W+1:0]   sum;
    logic                              eff_sub;
    special_e                          spec;
    logic                              spec_sign;
    logic                              invalid;
  } sum_t;

endpackage

//--- hw/fadd_align.sv
// first adder stage: unpacks and classifies operands, orders them and aligns the smaller one
`include "fadd_defs.svh"

module fadd_align (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  en,
  input  fadd_pkg::fadd_op_e    op,
  input  fadd_pkg::round_mode_e rmode,
  input  fadd_pkg::fp32_t       a,
  input  fadd_pkg::fp32_t       b,
  output fadd_pkg::align_t      align
);
  import fadd_pkg::*;

  localparam int SIG_W = `FP_FRAC_W + 1;
  localparam int EXT_W = SIG_W + `FP_GRS_W;

  logic                              b_sign;
  logic                              a_nan, b_nan, a_snan, b_snan;
  logic                              a_inf, b_inf, inf_diff;
  logic [`FP_EXP_W+`FP_FRAC_W-1:0]   a_mag, b_mag;
  logic [SIG_W-1:0]                  a_sig, b_sig, sig_small;
  logic                              a_big;
  logic [`FP_EXP_W-1:0]              exp_small, exp_diff;
  logic [EXT_W-1:0]                  small_ext, small_shift, lost_mask;
  align_t                            align_d;

  // subtract is an add with b negated
  assign b_sign = b.sign ^ (op == FADD_SUB);

  assign a_nan  = (a.exp == `FP_EXP_MAX) && (a.frac != '0);
  assign b_nan  = (b.exp == `FP_EXP_MAX) && (b.frac != '0);
  assign a_snan = a_nan && !a.frac[`FP_FRAC_W-1];
  assign b_snan = b_nan && !b.frac[`FP_FRAC_W-1];
  assign a_inf  = (a.exp == `FP_EXP_MAX) && (a.frac == '0);
  assign b_inf  = (b.exp == `FP_EXP_MAX) && (b.frac == '0);
  assign inf_diff = a_inf && b_inf && (a.sign != b_sign);

  // denormals read as zero
  assign a_mag = (a.exp == '0) ? '0 : {a.exp, a.frac};
  assign b_mag = (b.exp == '0) ? '0 : {b.exp, b.frac};
  assign a_sig = (a.exp == '0) ? '0 : {1'b1, a.frac};
  assign b_sig = (b.exp == '0) ? '0 : {1'b1, b.frac};

  assign a_big     = a_mag >= b_mag;
  assign sig_small = a_big ? b_sig : a_sig;
  assign exp_small = a_big ? b.exp : a.exp;
  assign exp_diff  = (a_big ? a.exp : b.exp) - exp_small;
  assign small_ext = {sig_small, {`FP_GRS_W{1'b0}}};
  assign small_shift = small_ext >> exp_diff;
  assign lost_mask   = (EXT_W'(1) << exp_diff) - EXT_W'(1);

  always_comb begin
    align_d.valid     = en;
    align_d.rmode     = rmode;
    align_d.sign      = a_big ? a.sign : b_sign;
    align_d.eff_sub   = a.sign ^ b_sign;
    align_d.exp       = a_big ? a.exp : b.exp;
    align_d.big_sig   = a_big ? a_sig : b_sig;
    // bits shifted out fold into sticky
    if (exp_diff >= `FP_ALIGN_MAX) begin
      align_d.small_sig = {{(EXT_W-1){1'b0}}, |sig_small};
    end else begin
      align_d.small_sig = {small_shift[EXT_W-1:1],
                           small_shift[0] | (|(small_ext & lost_mask))};
    end
    if (a_nan || b_nan || inf_diff) begin
      align_d.spec = SPEC_NAN;
    end else if (a_inf || b_inf) begin
      align_d.spec = SPEC_INF;
    end else begin
      align_d.spec = SPEC_NONE;
    end
    align_d.spec_sign = a_inf ? a.sign : b_sign;
    align_d.invalid   = a_snan || b_snan || inf_diff;
  end

  always_ff @(posedge clk) begin
    align <= align_d;
    if (rst) begin
      align.valid <= 1'b0;
    end
  end

  // ordering by magnitude keeps the difference non-negative
  assert property (@(posedge clk) disable iff (rst)
    align.valid |-> align.small_sig <= {align.big_sig, {`FP_GRS_W{1'b0}}});

endmodule

//--- hw/fadd_sum.sv
// second adder stage: adds or subtracts the aligned significands
`include "fadd_defs.svh"

module fadd_sum (
  input  logic             clk,
  input  logic             rst,
  input  fadd_pkg::align_t align,
  output fadd_pkg::sum_t   sum
);
  import fadd_pkg::*;

  localparam int EXT_W = `FP_FRAC_W + 1 + `FP_GRS_W;
  localparam int SUM_W = EXT_W + 1;

  logic [SUM_W-1:0] big_ext;
  logic [SUM_W-1:0] small_ext;
  sum_t             sum_d;

  assign big_ext   = {1'b0, align.big_sig, {`FP_GRS_W{1'b0}}};
  assign small_ext = {1'b0, align.small_sig};

  always_comb begin
    sum_d.valid     = align.valid;
    sum_d.rmode     = align.rmode;
    sum_d.sign      = align.sign;
    sum_d.exp       = align.exp;
    // extra top bit holds the carry of an add
    if (align.eff_sub) begin
      sum_d.sum = big_ext - small_ext;
    end else begin
      sum_d.sum = big_ext + small_ext;
    end
    sum_d.eff_sub   = align.eff_sub;
    sum_d.spec      = align.spec;
    sum_d.spec_sign = align.spec_sign;
    sum_d.invalid   = align.invalid;
  end

  always_ff @(posedge clk) begin
    sum <= sum_d;
    if (rst) begin
      sum.valid <= 1'b0;
    end
  end

  // larger minus smaller cannot carry out
  assert property (@(posedge clk) disable iff (rst)
    align.valid && align.eff_sub |=> !sum.sum[SUM_W-1]);

endmodule

//--- hw/fadd_normround.sv
// third adder stage: normalizes, rounds, applies limits and specials, drives the result
`include "fadd_defs.svh"

module fadd_normround (
  input  logic                  clk,
  input  logic                  rst,
  input  fadd_pkg::sum_t        sum,
  output fadd_pkg::fp32_t       res,
  output fadd_pkg::fadd_flags_t flags,
  output logic                  res_valid
);
  import fadd_pkg::*;

  localparam int SIG_W = `FP_FRAC_W + 1;
  localparam int EXT_W = SIG_W + `FP_GRS_W;
  localparam int SUM_W = EXT_W + 1;

  logic [4:0]          lzc;
  logic                lz_found;
  logic [EXT_W-1:0]    norm;
  logic signed [9:0]   exp_norm, exp_rnd;
  logic                rnd_lsb, rnd_g, rnd_st, rnd_up, inexact;
  logic [SIG_W:0]      mant_rnd;
  logic                ovf_to_max, zero_sign;
  fp32_t               res_d;
  fadd_flags_t         flags_d;

  // leading zeros below the carry bit
  always_comb begin
    lzc = '0;
    lz_found = 1'b0;
    for (int i = EXT_W - 1; i >= 0; i--) begin
      if (!lz_found) begin
        if (sum.sum[i]) begin
          lz_found = 1'b1;
        end else begin
          lzc = lzc + 5'd1;
        end
      end
    end
  end

  always_comb begin
    if (sum.sum[SUM_W-1]) begin
      norm     = {sum.sum[SUM_W-1:2], |sum.sum[1:0]};
      exp_norm = signed'({2'b00, sum.exp}) + 10'sd1;
    end else begin
      norm     = sum.sum[EXT_W-1:0] << lzc;
      exp_norm = signed'({2'b00, sum.exp}) - signed'({5'b00000, lzc});
    end
  end

  assign rnd_lsb = norm[`FP_GRS_W];
  assign rnd_g   = norm[`FP_GRS_W-1];
  assign rnd_st  = |norm[`FP_GRS_W-2:0];
  assign inexact = rnd_g | rnd_st;

  always_comb begin
    case (sum.rmode)
      RND_EVEN:  rnd_up = rnd_g & (rnd_st | rnd_lsb);
      RND_PLUS:  rnd_up = !sum.sign & inexact;
      RND_MINUS: rnd_up = sum.sign & inexact;
      default:   rnd_up = 1'b0;
    endcase
  end

  // carry out of rounding bumps the exponent
  assign mant_rnd = {1'b0, norm[EXT_W-1:`FP_GRS_W]} + (SIG_W+1)'(rnd_up);
  assign exp_rnd  = exp_norm + signed'({9'b0, mant_rnd[SIG_W]});

  assign ovf_to_max = (sum.rmode == RND_TRUNC) ||
                      (sum.rmode == RND_PLUS && sum.sign) ||
                      (sum.rmode == RND_MINUS && !sum.sign);

  // both operands zero with the same sign keep it
  assign zero_sign = (sum.rmode == RND_MINUS) || (!sum.eff_sub && sum.sign);

  always_comb begin
    res_d   = '0;
    flags_d = '0;
    if (sum.spec == SPEC_NAN) begin
      res_d = `FP_QNAN;
      flags_d.invalid = sum.invalid;
    end else if (sum.spec == SPEC_INF) begin
      res_d.sign = sum.spec_sign;
      res_d.exp  = '1;
      flags_d.invalid = sum.invalid;
    end else if (sum.sum == '0) begin
      res_d.sign = zero_sign;
    end else if (exp_rnd >= `FP_EXP_MAX) begin
      res_d.sign = sum.sign;
      if (ovf_to_max) begin
        res_d.exp  = `FP_EXP_W'(`FP_EXP_MAX - 1);
        res_d.frac = '1;
      end else begin
        res_d.exp  = '1;
      end
      flags_d.overflow = 1'b1;
      flags_d.inexact  = 1'b1;
    end else if (exp_rnd < 1) begin
      // below normal range, flush
      res_d.sign = sum.sign;
      flags_d.underflow = 1'b1;
      flags_d.inexact   = 1'b1;
    end else begin
      res_d.sign = sum.sign;
      res_d.exp  = exp_rnd[`FP_EXP_W-1:0];
      res_d.frac = mant_rnd[SIG_W] ? mant_rnd[SIG_W-1:1] : mant_rnd[SIG_W-2:0];
      flags_d.inexact = inexact;
    end
  end

  always_ff @(posedge clk) begin
    res   <= res_d;
    flags <= flags_d;
    if (rst) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= sum.valid;
    end
  end

  // a NaN result raises invalid at most
  assert property (@(posedge clk) disable iff (rst)
    sum.valid && sum.spec == SPEC_NAN |=>
      !flags.overflow && !flags.underflow && !flags.inexact);

endmodule

//--- hw/fadd_top.sv
// top of the three-stage binary32 adder, one result per cycle with three cycles latency
module fadd_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  en,
  input  fadd_pkg::fadd_op_e    op,
  input  fadd_pkg::round_mode_e rmode,
  input  fadd_pkg::fp32_t       a,
  input  fadd_pkg::fp32_t       b,
  output fadd_pkg::fp32_t       res,
  output fadd_pkg::fadd_flags_t flags,
  output logic                  res_valid
);
  import fadd_pkg::*;

  align_t stage_align;
  sum_t   stage_sum;

  fadd_align fadd_align_inst (
    .clk   (clk),
    .rst   (rst),
    .en    (en),
    .op    (op),
    .rmode (rmode),
    .a     (a),
    .b     (b),
    .align (stage_align)
  );

  fadd_sum fadd_sum_inst (
    .clk   (clk),
    .rst   (rst),
    .align (stage_align),
    .sum   (stage_sum)
  );

  fadd_normround fadd_normround_inst (
    .clk       (clk),
    .rst       (rst),
    .sum       (stage_sum),
    .res       (res),
    .flags     (flags),
    .res_valid (res_valid)
  );

endmodule

//--- sim/tb_clock.sv
// testbench clock and reset source, reset held high for the first few rising edges
module tb_clock #(
  parameter int PERIOD     = 4,
  parameter int RST_CYCLES = 4
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
  end

endmodule

//--- sim/fadd_checker.sv
// testbench checker that predicts every adder result from its operands and compares it
`include "fadd_defs.svh"

module fadd_checker (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  en,
  input  fadd_pkg::fadd_op_e    op,
  input  fadd_pkg::round_mode_e rmode,
  input  fadd_pkg::fp32_t       a,
  input  fadd_pkg::fp32_t       b,
  input  fadd_pkg::fp32_t       res,
  input  fadd_pkg::fadd_flags_t flags,
  input  logic                  res_valid,
  input  logic [8*24-1:0]       test_name,
  input  logic                  test_done,
  output int                    tests_passed,
  output int                    tests_failed
);
  import fadd_pkg::*;

  logic [35:0] expect_q[$];
  int          issue_q[$];
  int          cycle = 0;
  int          test_errs = 0;
  int          n_pass = 0;
  int          n_fail = 0;
  logic        rst_q = 1'b1;
  logic [35:0] exp_v;
  logic [35:0] act_v;
  int          issued;

  assign tests_passed = n_pass;
  assign tests_failed = n_fail;

  // both operands placed exactly on one integer grid and rounded once
  function automatic logic [35:0] ref_add(input logic [31:0] x, input logic [31:0] y,
                                          input logic sub, input logic [1:0] mode);
    logic         sx, sy, sr, x_nan, y_nan, x_inf, y_inf, up, inexact, to_max;
    logic [299:0] mx, my, mag, rem, half, top;
    int           ex, ey, e_lo, p, e_res;
    logic [24:0]  mant;
    logic [3:0]   fl;
    logic [31:0]  r;
    sx = x[31];
    sy = y[31] ^ sub;
    ex = int'(x[30:23]);
    ey = int'(y[30:23]);
    x_nan = (ex == `FP_EXP_MAX) && (x[22:0] != 0);
    y_nan = (ey == `FP_EXP_MAX) && (y[22:0] != 0);
    x_inf = (ex == `FP_EXP_MAX) && (x[22:0] == 0);
    y_inf = (ey == `FP_EXP_MAX) && (y[22:0] == 0);
    fl = 4'b0000;
    r = 32'h0;
    if (x_nan || y_nan) begin
      r = `FP_QNAN;
      fl[3] = (x_nan && !x[22]) || (y_nan && !y[22]);
    end else if (x_inf && y_inf && sx != sy) begin
      r = `FP_QNAN;
      fl[3] = 1'b1;
    end else if (x_inf || y_inf) begin
      r = {x_inf ? sx : sy, 8'hff, 23'h0};
    end else if (ex == 0 && ey == 0) begin
      r = {(mode == RND_MINUS) || (sx && sy), 31'h0};
    end else if (ex == 0) begin
      r = {sy, y[30:0]};
    end else if (ey == 0) begin
      r = x;
    end else begin
      e_lo = (ex < ey) ? ex : ey;
      mx = {276'h0, 1'b1, x[22:0]} << (ex - e_lo);
      my = {276'h0, 1'b1, y[22:0]} << (ey - e_lo);
      sr = (mx >= my) ? sx : sy;
      if (sx == sy) begin
        mag = mx + my;
      end else if (mx >= my) begin
        mag = mx - my;
      end else begin
        mag = my - mx;
      end
      if (mag == 0) begin
        r = {mode == RND_MINUS, 31'h0};
      end else begin
        p = 0;
        for (int i = 0; i < 300; i++) begin
          if (mag[i]) begin
            p = i;
          end
        end
        e_res = e_lo + p - 23;
        rem = '0;
        half = '0;
        if (p > 23) begin
          top = mag >> (p - 23);
          rem = mag & ((300'h1 << (p - 23)) - 300'h1);
          half = 300'h1 << (p - 24);
        end else begin
          top = mag << (23 - p);
        end
        mant = {1'b0, top[23:0]};
        inexact = (rem != 0);
        case (mode)
          RND_EVEN:  up = inexact && ((rem > half) || (rem == half && mant[0]));
          RND_PLUS:  up = !sr && inexact;
          RND_MINUS: up = sr && inexact;
          default:   up = 1'b0;
        endcase
        mant = mant + 25'(up);
        if (mant[24]) begin
          mant = mant >> 1;
          e_res = e_res + 1;
        end
        to_max = (mode == RND_TRUNC) || (mode == RND_PLUS && sr) || (mode == RND_MINUS && !sr);
        if (e_res >= `FP_EXP_MAX) begin
          r = to_max ? {sr, 8'hfe, 23'h7fffff} : {sr, 8'hff, 23'h0};
          fl = 4'b0101;
        end else if (e_res < 1) begin
          r = {sr, 31'h0};
          fl = 4'b0011;
        end else begin
          r = {sr, e_res[7:0], mant[22:0]};
          fl[0] = inexact;
        end
      end
    end
    return {fl, r};
  endfunction

  always @(posedge clk) begin
    if (rst_q && !rst && res_valid !== 1'b0) begin
      $display("res_valid is not low right after reset");
      test_errs++;
    end
    if (!rst) begin
      if (res_valid) begin
        if (expect_q.size() == 0) begin
          $display("a result %h arrived while no operation was pending", res);
          test_errs++;
        end else begin
          exp_v = expect_q.pop_front();
          issued = issue_q.pop_front();
          act_v = {flags, res};
          if (act_v !== exp_v) begin
            $display("ERR %0s expected res=%h flags=%b actual res=%h flags=%b",
                     test_name, exp_v[31:0], exp_v[35:32], act_v[31:0], act_v[35:32]);
            test_errs++;
          end
          if (cycle - issued != 3) begin
            $display("a result in %0s came %0d cycles after its operands instead of 3",
                     test_name, cycle - issued);
            test_errs++;
          end
        end
      end
      if (en) begin
        expect_q.push_back(ref_add(a, b, op == FADD_SUB, rmode));
        issue_q.push_back(cycle);
      end
      if (test_done) begin
        if (expect_q.size() != 0) begin
          $display("%0s ended with %0d results still missing", test_name, expect_q.size());
          test_errs++;
          expect_q.delete();
          issue_q.delete();
        end
        if (test_errs == 0) begin
          $display("PASS %0s", test_name);
          n_pass++;
        end else begin
          $display("FAIL %0s with %0d errors", test_name, test_errs);
          n_fail++;
        end
        test_errs = 0;
      end
    end
    rst_q = rst;
    cycle++;
  end

endmodule

//--- sim/fadd_tb.sv
// testbench top that drives the adder through directed, special, limit and random operations
module fadd_tb;
  import fadd_pkg::*;

  localparam int PERIOD    = 4;
  localparam int N_RAND    = 100;
  localparam int N_BURST   = 40;
  localparam int N_TESTS   = 5;
  localparam int TOTAL_OPS = 32 + 4 * N_RAND + 12 + 16 + N_BURST;
  // reset, then per test one cycle to stop, three to drain and one for the done pulse
  localparam int DRAIN_CYCLES = 4 + N_TESTS * 5 + 2;

  logic            clk;
  logic            rst;
  logic            en;
  fadd_op_e        op;
  round_mode_e     rmode;
  fp32_t           a;
  fp32_t           b;
  fp32_t           res;
  fadd_flags_t     flags;
  logic            res_valid;
  logic [8*24-1:0] test_name;
  logic            test_done;
  int              tests_passed;
  int              tests_failed;
  logic [31:0]     seed;

  tb_clock #(.PERIOD(PERIOD), .RST_CYCLES(4)) tb_clock_inst (.clk(clk), .rst(rst));

  fadd_top fadd_top_inst (
    .clk       (clk),
    .rst       (rst),
    .en        (en),
    .op        (op),
    .rmode     (rmode),
    .a         (a),
    .b         (b),
    .res       (res),
    .flags     (flags),
    .res_valid (res_valid)
  );

  fadd_checker fadd_checker_inst (
    .clk          (clk),
    .rst          (rst),
    .en           (en),
    .op           (op),
    .rmode        (rmode),
    .a            (a),
    .b            (b),
    .res          (res),
    .flags        (flags),
    .res_valid    (res_valid),
    .test_name    (test_name),
    .test_done    (test_done),
    .tests_passed (tests_passed),
    .tests_failed (tests_failed)
  );

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // exponent kept away from zero and all ones
  function automatic logic [31:0] rand_operand(input logic [31:0] r, input logic wide);
    logic [7:0] e;
    if (wide) begin
      e = 8'd40 + {1'b0, r[30:24]};
    end else begin
      e = 8'd120 + {5'b0, r[26:24]};
    end
    return {r[31], e, r[22:0]};
  endfunction

  task automatic issue_op(input logic [31:0] x, input logic [31:0] y,
                          input fadd_op_e o, input round_mode_e m);
    @(posedge clk);
    #1;
    en = 1'b1;
    a = x;
    b = y;
    op = o;
    rmode = m;
  endtask

  task automatic random_op(input round_mode_e m, input logic wide);
    logic [31:0] x;
    logic [31:0] y;
    seed = lcg(seed);
    x = rand_operand(seed, wide);
    seed = lcg(seed);
    y = rand_operand(seed, wide);
    seed = lcg(seed);
    issue_op(x, y, fadd_op_e'(seed[15]), m);
  endtask

  // stop issuing, let the pipeline drain, then pulse done
  task automatic end_test();
    @(posedge clk);
    #1;
    en = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    test_done = 1'b1;
    @(posedge clk);
    #1;
    test_done = 1'b0;
  endtask

  task automatic exact_set(input round_mode_e m);
    issue_op(32'h3f800000, 32'h3f800000, FADD_ADD, m);
    issue_op(32'h40400000, 32'h3f800000, FADD_SUB, m);
    issue_op(32'h3fc00000, 32'h3e800000, FADD_ADD, m);
    issue_op(32'h40200000, 32'h40800000, FADD_SUB, m);
    // cancellation and signed zeros
    issue_op(32'h40a00000, 32'h40a00000, FADD_SUB, m);
    issue_op(32'hc0400000, 32'h40400000, FADD_ADD, m);
    issue_op(32'h80000000, 32'h80000000, FADD_ADD, m);
    issue_op(32'h00000000, 32'h00000000, FADD_SUB, m);
  endtask

  task automatic special_set();
    issue_op(32'h7fc00001, 32'h3f800000, FADD_ADD, RND_EVEN);
    issue_op(32'h7f800001, 32'h3f800000, FADD_ADD, RND_EVEN);
    issue_op(32'h3f800000, 32'hff800001, FADD_SUB, RND_EVEN);
    issue_op(32'hffc00000, 32'h7f800000, FADD_ADD, RND_EVEN);
    issue_op(32'h7f800000, 32'h7f800000, FADD_SUB, RND_EVEN);
    issue_op(32'h7f800000, 32'hff800000, FADD_ADD, RND_EVEN);
    issue_op(32'h7f800000, 32'h3f800000, FADD_ADD, RND_EVEN);
    issue_op(32'hc0a00000, 32'hff800000, FADD_ADD, RND_EVEN);
    issue_op(32'h40400000, 32'h7f800000, FADD_SUB, RND_EVEN);
    // denormals read as zero
    issue_op(32'h00000001, 32'h3f800000, FADD_ADD, RND_EVEN);
    issue_op(32'h807fffff, 32'h807fffff, FADD_ADD, RND_EVEN);
    issue_op(32'h00400000, 32'h3f800000, FADD_SUB, RND_EVEN);
  endtask

  task automatic limit_set(input round_mode_e m);
    issue_op(32'h7f7fffff, 32'h7f7fffff, FADD_ADD, m);
    issue_op(32'hff7fffff, 32'h7f7fffff, FADD_SUB, m);
    issue_op(32'h00c00000, 32'h00800000, FADD_SUB, m);
    issue_op(32'h80c00000, 32'h00800000, FADD_ADD, m);
  endtask

  initial begin
    en = 1'b0;
    op = FADD_ADD;
    rmode = RND_EVEN;
    a = '0;
    b = '0;
    test_done = 1'b0;
    seed = 32'd47;
    test_name = "exact_normal";
    wait (rst == 1'b0);
    for (int m = 0; m < 4; m++) begin
      exact_set(round_mode_e'(m[1:0]));
    end
    end_test();
    test_name = "random_rounding";
    for (int m = 0; m < 4; m++) begin
      for (int i = 0; i < N_RAND; i++) begin
        random_op(round_mode_e'(m[1:0]), i[0]);
      end
    end
    end_test();
    test_name = "specials";
    special_set();
    end_test();
    test_name = "limits";
    for (int m = 0; m < 4; m++) begin
      limit_set(round_mode_e'(m[1:0]));
    end
    end_test();
    test_name = "burst_timing";
    for (int i = 0; i < N_BURST; i++) begin
      random_op(round_mode_e'(seed[17:16]), seed[18]);
    end
    end_test();
    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && tests_passed == N_TESTS) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin
    #(2 * (TOTAL_OPS + DRAIN_CYCLES) * PERIOD);
    $display("timeout, the run did not finish in the expected time");
    $display("Some tests failed");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+hw
hw/fadd_pkg.sv
hw/fadd_align.sv
hw/fadd_sum.sv
hw/fadd_normround.sv
hw/fadd_top.sv
sim/tb_clock.sv
sim/fadd_checker.sv
sim/fadd_tb.sv

//--- Bender.yml
package:
  name: fadd

sources:
  - include_dirs:
      - hw
    files:
      - hw/fadd_pkg.sv
      - hw/fadd_align.sv
      - hw/fadd_sum.sv
      - hw/fadd_normround.sv
      - hw/fadd_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/tb_clock.sv
      - sim/fadd_checker.sv
      - sim/fadd_tb.sv
